// ==== dv/rx_desc_stim.txt ====
// rdlen base wthresh enable tail engine_total (hex, one step per line)
// rdlen 0 ends the list
10 0000001234567000 08 1 0064 064
10 0000001234567000 05 1 0014 094
10 0000001234567000 05 0 003c 094
10 0000001234567000 01 1 003c 0bc
10 00000abcd0000000 20 1 007f 0ff
10 00000abcd0000000 00 1 0005 105
0 0 0 0 0 0

// ==== verilog.f ====
common/rxd_ring_pkg.sv
common/rxd_msg_pkg.sv
rtl/ring_tracker.sv
rtl/local_desc_queue.sv
dma_sequencer/dma_sequencer.sv
rtl/engine_dispatch.sv
rtl/rx_desc_ctrl.sv
dv/rx_desc_ctrl_sva.sv
dv/rx_desc_ctrl_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert -Wno-fatal
TOP      = rx_desc_ctrl_tb
FILELIST = verilog.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== dv/rx_desc_ctrl_tb.sv ====
`timescale 1ns/10ps

module rx_desc_ctrl_tb import rxd_ring_pkg::*, rxd_msg_pkg::*; ();

	localparam int MAX_STEPS = 16;
	localparam int STIM_COLS = 6;

	logic        aclk;
	logic        aresetn;
	rxd_cfg_t    cfg;
	logic [15:0] rdt;
	logic        rdt_set;
	logic [15:0] rdh_fb;
	dma_cmd_t    idma_cmd;
	logic        idma_cmd_valid;
	logic        idma_cmd_ready;
	logic        idma_rsp_valid;
	logic        idma_rsp_last;
	logic        idma_rsp_ready;
	engine_cmd_t reng_cmd;
	logic        reng_cmd_valid;
	logic        reng_cmd_ready;
	logic        reng_rsp_valid;
	logic        reng_rsp_last;
	logic        reng_rsp_ready;

	logic [63:0] stim_mem [0:MAX_STEPS*STIM_COLS-1];
	int          num_steps;
	bit          steps_loaded;
	logic [15:0] lfsr_state;
	int          value_errors;
	int          other_errors;

	// Reference model of the ring and the local store
	int          ring_len;
	logic [63:0] m_base;
	int          m_thresh;
	int          m_tail;
	int          m_curr;
	int          m_head;
	int          m_in_tail;
	int          m_out_head;
	int          m_free;
	int          m_eng_idx;
	int          m_fetched;
	int          m_eng_count;
	int          m_pending;

	// DMA and engine model state
	logic [31:0] cmd_words [0:2];
	int          word_cnt;
	bit          rsp_wait;
	int          rsp_delay;
	bit          eng_wait;
	int          eng_delay;
	int          idle_cnt;

	rx_desc_ctrl rx_desc_ctrl_inst (.*);

	always #10 aclk = ~aclk;

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[14:0],
				lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		assert (exp === act) else begin
			value_errors++;
			$display("FAILED time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
		end
	endtask

	task automatic check_true(input string what, input bit ok);
		assert (ok) else begin
			other_errors++;
			$display("ERROR time=%0t %s", $time, what);
		end
	endtask

	////////////////////////////////////////
	// Three-word DMA command against the ring model
	task automatic check_dma_cmd();
		logic [31:0] w0;
		logic [63:0] haddr;
		logic [63:0] exp_addr;
		int          n;
		int          room;
		int          fresh;
		int          exp_n;
		w0 = cmd_words[0];
		haddr = {cmd_words[2], cmd_words[1]};
		n = int'(w0[27:16]) / 16;
		check_value("idma_cmd word0 spare bits", 0, w0[30:28]);
		if (w0[31]) begin
			room = ring_len - m_head;
			check_true("write-back count exceeds completed descriptors, burst or wrap",
				n >= 1 && n <= m_pending && n <= MAX_BURST && n <= room);
			check_true("write-back issued below the threshold",
				n >= m_thresh || n == room || n == MAX_BURST);
			check_value("idma_cmd wb local addr", m_out_head * 16, w0[15:0]);
			exp_addr = m_base + 64'(m_head) * 16;
			check_value("idma_cmd wb host addr", {exp_addr[63:4], 4'hC}, haddr);
			m_head = (m_head + n) % ring_len;
			m_out_head = (m_out_head + n) % LOCAL_DESC_NUM;
			m_free += n;
			m_pending -= n;
		end else begin
			fresh = (m_tail + ring_len - m_curr) % ring_len;
			exp_n = fresh;
			if (ring_len - m_curr < exp_n)
				exp_n = ring_len - m_curr;
			if (m_free < exp_n)
				exp_n = m_free;
			if (exp_n > MAX_BURST)
				exp_n = MAX_BURST;
			check_value("idma_cmd fetch bytes", exp_n * 16, w0[27:16]);
			check_value("idma_cmd fetch local addr", m_in_tail * 16, w0[15:0]);
			check_value("idma_cmd fetch host addr", m_base + 64'(m_curr) * 16, haddr);
			m_curr = (m_curr + exp_n) % ring_len;
			m_in_tail = (m_in_tail + exp_n) % LOCAL_DESC_NUM;
			m_free -= exp_n;
			m_fetched += exp_n;
		end
	endtask

	////////////////////////////////////////
	// DMA and engine models, sampled at the edge, driven 2 ns later
	initial begin
		idma_cmd_ready = 0;
		idma_rsp_valid = 0;
		idma_rsp_last  = 0;
		reng_cmd_ready = 0;
		reng_rsp_valid = 0;
		reng_rsp_last  = 0;
		word_cnt = 0;
		rsp_wait = 0;
		eng_wait = 0;
		idle_cnt = 0;
		forever begin
			@(posedge aclk);
			if (aresetn) begin
				if (idma_cmd_valid && idma_cmd_ready) begin
					check_value("idma_cmd.last", word_cnt == 2, idma_cmd.last);
					cmd_words[word_cnt] = idma_cmd.data;
					word_cnt++;
					if (word_cnt == 3) begin
						check_dma_cmd();
						word_cnt = 0;
						rsp_wait = 1;
						rsp_delay = rand_bits(3);
					end
				end
				if (idma_rsp_valid && idma_rsp_ready)
					rsp_wait = 0;
				if (reng_cmd_valid && reng_cmd_ready) begin
					check_value("reng_cmd.addr", (m_eng_idx * 16) % 65536, reng_cmd.addr);
					check_true("engine command without a fetched descriptor",
						m_eng_count < m_fetched);
					m_eng_idx = (m_eng_idx + 1) % LOCAL_DESC_NUM;
					m_eng_count++;
					eng_wait = 1;
					eng_delay = rand_bits(3);
				end
				if (reng_rsp_valid && reng_rsp_ready) begin
					eng_wait = 0;
					m_pending++;
				end
				if (!idma_cmd_valid && !reng_cmd_valid && !rsp_wait && !eng_wait)
					idle_cnt++;
				else
					idle_cnt = 0;
			end
			#2;
			idma_cmd_ready = rand_bits(2) != 0;
			reng_cmd_ready = rand_bits(2) != 0;
			if (!rsp_wait) begin
				idma_rsp_valid = 0;
			end else if (!idma_rsp_valid) begin
				if (rsp_delay == 0)
					idma_rsp_valid = 1;
				else
					rsp_delay--;
			end
			idma_rsp_last = idma_rsp_valid;
			if (!eng_wait) begin
				reng_rsp_valid = 0;
			end else if (!reng_rsp_valid) begin
				if (eng_delay == 0)
					reng_rsp_valid = 1;
				else
					eng_delay--;
			end
			reng_rsp_last = reng_rsp_valid;
		end
	end

	task automatic check_idle_outputs();
		check_value("idma_cmd_valid", 0, idma_cmd_valid);
		check_value("idma_rsp_ready", 0, idma_rsp_ready);
		check_value("reng_cmd_valid", 0, reng_cmd_valid);
		check_value("reng_rsp_ready", 0, reng_rsp_ready);
		check_value("rdh_fb", 0, rdh_fb);
	endtask

	// One stimulus line
	task automatic run_step(input int s);
		int exp_total;
		int thresh_floor;
		@(posedge aclk);
		#2;
		ring_len = int'(stim_mem[s*STIM_COLS]) * 8;
		m_base = stim_mem[s*STIM_COLS+1];
		m_thresh = int'(stim_mem[s*STIM_COLS+2]);
		m_tail = int'(stim_mem[s*STIM_COLS+4]);
		exp_total = int'(stim_mem[s*STIM_COLS+5]);
		cfg.rdlen = RDLEN_W'(stim_mem[s*STIM_COLS]);
		cfg.base = m_base;
		cfg.wthresh = 6'(m_thresh);
		cfg.enable = stim_mem[s*STIM_COLS+3][0];
		rdt = 16'(m_tail);
		rdt_set = 1;
		@(posedge aclk);
		#2;
		rdt_set = 0;
		if (cfg.enable) begin
			while (!(m_eng_count == exp_total && idle_cnt >= 16))
				@(negedge aclk);
			thresh_floor = (m_thresh > 0) ? m_thresh : 1;
			check_true("completed descriptors at or above threshold left unwritten",
				m_pending < thresh_floor);
			check_value("fetched descriptors", exp_total, m_fetched);
			check_value("rdh_fb", m_head, rdh_fb);
		end else begin
			// Disabled, nothing may start
			repeat (200) begin
				@(posedge aclk);
				check_true("command issued while disabled",
					!idma_cmd_valid && !reng_cmd_valid);
			end
			check_value("engine commands", exp_total, m_eng_count);
		end
	endtask

	initial begin
		aclk = 0;
		aresetn = 0;
		cfg = '0;
		rdt = '0;
		rdt_set = 0;
		lfsr_state = 16'd29390;
		value_errors = 0;
		other_errors = 0;
		steps_loaded = 0;
		m_curr = 0;
		m_head = 0;
		m_in_tail = 0;
		m_out_head = 0;
		m_free = LOCAL_DESC_NUM;
		m_eng_idx = 0;
		m_fetched = 0;
		m_eng_count = 0;
		m_pending = 0;
		for (int i = 0; i < MAX_STEPS * STIM_COLS; i++)
			stim_mem[i] = '0;
		$readmemh("dv/rx_desc_stim.txt", stim_mem);
		num_steps = 0;
		while (num_steps < MAX_STEPS && stim_mem[num_steps*STIM_COLS] != 0)
			num_steps++;
		steps_loaded = 1;
		check_true("stimulus file holds no steps", num_steps > 0);

		repeat (4) @(posedge aclk);
		check_idle_outputs();
		@(posedge aclk);
		#2;
		aresetn = 1;
		@(posedge aclk);
		check_idle_outputs();

		for (int s = 0; s < num_steps; s++)
			run_step(s);

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog, 4000 cycles per step
	initial begin
		wait (steps_loaded);
		repeat ((num_steps + 1) * 4000) @(posedge aclk);
		$display("Timeout: run did not finish within %0d cycles", (num_steps + 1) * 4000);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== dv/rx_desc_ctrl_sva.sv ====
`timescale 1ns/10ps

module rx_desc_ctrl_sva import rxd_msg_pkg::*; (
	input logic        aclk,
	input logic        aresetn,
	input dma_cmd_t    idma_cmd,
	input logic        idma_cmd_valid,
	input logic        idma_cmd_ready,
	input logic        idma_rsp_ready,
	input engine_cmd_t reng_cmd,
	input logic        reng_cmd_valid,
	input logic        reng_cmd_ready,
	input logic        reng_rsp_ready,
	input logic        fetch_done,
	input logic        wback_done,
	input logic        engine_taken,
	input logic        engine_done
);

	////////////////////////////////////////
	// Held payload under back-pressure
	dma_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		idma_cmd_valid && !idma_cmd_ready |=> idma_cmd_valid && $stable(idma_cmd))
		else $error("DMA command changed before acceptance");

	eng_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		reng_cmd_valid && !reng_cmd_ready |=> reng_cmd_valid && $stable(reng_cmd))
		else $error("engine command changed before acceptance");

	// Quiet outputs in reset
	reset_quiet: assert property (@(posedge aclk) !aresetn |->
		!idma_cmd_valid && !idma_rsp_ready && !reng_cmd_valid && !reng_rsp_ready &&
		!fetch_done && !wback_done && !engine_taken && !engine_done)
		else $error("output active during reset");

endmodule

bind rx_desc_ctrl rx_desc_ctrl_sva rx_desc_ctrl_sva_inst (.*);

// ==== rtl/rx_desc_ctrl.sv ====
`timescale 1ns/10ps

module rx_desc_ctrl import rxd_ring_pkg::*, rxd_msg_pkg::*; (
	input  logic                  aclk,
	input  logic                  aresetn,

	// Host settings and ring pointers
	input  rxd_cfg_t              cfg,
	input  logic [DESC_PTR_W-1:0] rdt,
	input  logic                  rdt_set,
	output logic [DESC_PTR_W-1:0] rdh_fb,

	// DMA command and response
	output dma_cmd_t              idma_cmd,
	output logic                  idma_cmd_valid,
	input  logic                  idma_cmd_ready,
	input  logic                  idma_rsp_valid,
	input  logic                  idma_rsp_last,
	output logic                  idma_rsp_ready,

	// Receive engine command and response
	output engine_cmd_t           reng_cmd,
	output logic                  reng_cmd_valid,
	input  logic                  reng_cmd_ready,
	input  logic                  reng_rsp_valid,
	input  logic                  reng_rsp_last,
	output logic                  reng_rsp_ready
);

	logic [DESC_PTR_W-1:0]  host_head;
	logic [DESC_PTR_W-1:0]  host_curr;
	logic [DESC_PTR_W-1:0]  fresh_num;
	logic [DESC_PTR_W-1:0]  fetch_limit;
	logic [DESC_PTR_W-1:0]  wback_limit;
	logic                   ring_ready;
	logic [LOCAL_IDX_W-1:0] in_head;
	logic [LOCAL_IDX_W-1:0] in_tail;
	logic [LOCAL_IDX_W-1:0] out_head;
	logic [LOCAL_IDX_W:0]   in_num;
	logic [LOCAL_IDX_W:0]   out_num;
	logic [LOCAL_IDX_W:0]   local_free;
	logic                   fetch_done;
	logic [BURST_W-1:0]     fetch_num;
	logic                   wback_done;
	logic [BURST_W-1:0]     wback_num;
	logic                   engine_taken;
	logic                   engine_done;

	assign rdh_fb = host_head;

	////////////////////////////////////////
	// Host ring pointers
	ring_tracker ring_tracker_inst (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.cfg         (cfg),
		.rdt         (rdt),
		.rdt_set     (rdt_set),
		.fetch_done  (fetch_done),
		.fetch_num   (fetch_num),
		.wback_done  (wback_done),
		.wback_num   (wback_num),
		.host_head   (host_head),
		.host_curr   (host_curr),
		.fresh_num   (fresh_num),
		.fetch_limit (fetch_limit),
		.wback_limit (wback_limit),
		.ring_ready  (ring_ready)
	);

	// Local store queues
	local_desc_queue local_desc_queue_inst (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.fetch_done   (fetch_done),
		.fetch_num    (fetch_num),
		.wback_done   (wback_done),
		.wback_num    (wback_num),
		.engine_taken (engine_taken),
		.engine_done  (engine_done),
		.in_head      (in_head),
		.in_tail      (in_tail),
		.out_head     (out_head),
		.in_num       (in_num),
		.out_num      (out_num),
		.local_free   (local_free)
	);

	////////////////////////////////////////
	// Fetch and write-back commands
	dma_sequencer dma_sequencer_inst (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.cfg            (cfg),
		.ring_ready     (ring_ready),
		.host_head      (host_head),
		.host_curr      (host_curr),
		.fresh_num      (fresh_num),
		.fetch_limit    (fetch_limit),
		.wback_limit    (wback_limit),
		.out_num        (out_num),
		.local_free     (local_free),
		.in_tail        (in_tail),
		.out_head       (out_head),
		.idma_cmd_ready (idma_cmd_ready),
		.idma_rsp_valid (idma_rsp_valid),
		.idma_rsp_last  (idma_rsp_last),
		.idma_cmd       (idma_cmd),
		.idma_cmd_valid (idma_cmd_valid),
		.idma_rsp_ready (idma_rsp_ready),
		.fetch_done     (fetch_done),
		.fetch_num      (fetch_num),
		.wback_done     (wback_done),
		.wback_num      (wback_num)
	);

	// Receive engine handoff
	engine_dispatch engine_dispatch_inst (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.cfg            (cfg),
		.in_num         (in_num),
		.in_head        (in_head),
		.reng_cmd_ready (reng_cmd_ready),
		.reng_rsp_valid (reng_rsp_valid),
		.reng_rsp_last  (reng_rsp_last),
		.reng_cmd       (reng_cmd),
		.reng_cmd_valid (reng_cmd_valid),
		.reng_rsp_ready (reng_rsp_ready),
		.engine_taken   (engine_taken),
		.engine_done    (engine_done)
	);

endmodule

// ==== rtl/engine_dispatch.sv ====
`timescale 1ns/10ps

module engine_dispatch import rxd_ring_pkg::*, rxd_msg_pkg::*; (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  rxd_cfg_t               cfg,
	input  logic [LOCAL_IDX_W:0]   in_num,
	input  logic [LOCAL_IDX_W-1:0] in_head,
	input  logic                   reng_cmd_ready,
	input  logic                   reng_rsp_valid,
	input  logic                   reng_rsp_last,
	output engine_cmd_t            reng_cmd,
	output logic                   reng_cmd_valid,
	output logic                   reng_rsp_ready,
	output logic                   engine_taken,
	output logic                   engine_done
);

	typedef enum logic [1:0] {ENG_IDLE, ENG_CMD, ENG_WAIT} eng_state_t;

	eng_state_t eng_state;
	logic       launch;

	assign launch = (eng_state == ENG_IDLE) && cfg.enable && (in_num != '0);

	// One descriptor in the engine at a time
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			eng_state      <= ENG_IDLE;
			reng_cmd_valid <= 1'b0;
			reng_rsp_ready <= 1'b0;
			engine_taken   <= 1'b0;
			engine_done    <= 1'b0;
		end else begin
			engine_taken <= 1'b0;
			engine_done  <= 1'b0;
			case (eng_state)
				ENG_IDLE: begin
					if (launch) begin
						reng_cmd_valid <= 1'b1;
						eng_state      <= ENG_CMD;
					end
				end
				ENG_CMD: begin
					if (reng_cmd_valid && reng_cmd_ready) begin
						reng_cmd_valid <= 1'b0;
						reng_rsp_ready <= 1'b1;
						engine_taken   <= 1'b1;
						eng_state      <= ENG_WAIT;
					end
				end
				ENG_WAIT: begin
					// Retire into the output queue
					if (reng_rsp_valid && reng_rsp_last) begin
						reng_rsp_ready <= 1'b0;
						engine_done    <= 1'b1;
						eng_state      <= ENG_IDLE;
					end
				end
				default: eng_state <= ENG_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (launch)
			reng_cmd.addr <= CMD_ADDR_W'(in_head) * CMD_ADDR_W'(DESC_BYTES);
	end

endmodule

// ==== dma_sequencer/dma_sequencer.sv ====
`timescale 1ns/10ps

module dma_sequencer import rxd_ring_pkg::*, rxd_msg_pkg::*; (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  rxd_cfg_t               cfg,
	input  logic                   ring_ready,
	input  logic [DESC_PTR_W-1:0]  host_head,
	input  logic [DESC_PTR_W-1:0]  host_curr,
	input  logic [DESC_PTR_W-1:0]  fresh_num,
	input  logic [DESC_PTR_W-1:0]  fetch_limit,
	input  logic [DESC_PTR_W-1:0]  wback_limit,
	input  logic [LOCAL_IDX_W:0]   out_num,
	input  logic [LOCAL_IDX_W:0]   local_free,
	input  logic [LOCAL_IDX_W-1:0] in_tail,
	input  logic [LOCAL_IDX_W-1:0] out_head,
	input  logic                   idma_cmd_ready,
	input  logic                   idma_rsp_valid,
	input  logic                   idma_rsp_last,
	output dma_cmd_t               idma_cmd,
	output logic                   idma_cmd_valid,
	output logic                   idma_rsp_ready,
	output logic                   fetch_done,
	output logic [BURST_W-1:0]     fetch_num,
	output logic                   wback_done,
	output logic [BURST_W-1:0]     wback_num
);

	typedef enum logic [2:0] {
		SEQ_IDLE, SEQ_WORD0, SEQ_WORD1, SEQ_WORD2, SEQ_RSP, SEQ_SETTLE
	} seq_state_t;

	seq_state_t            seq_state;
	logic                  cmd_fire;
	logic                  wb_go;
	logic                  fetch_go;
	logic                  is_write;
	logic [BURST_W-1:0]    burst_num;
	logic [63:0]           host_addr;
	logic [DESC_PTR_W-1:0] wb_span;
	logic [DESC_PTR_W-1:0] fetch_span;
	logic [DESC_PTR_W-1:0] fetch_room;
	logic [BURST_W-1:0]    wb_cnt;
	logic [BURST_W-1:0]    fetch_cnt;
	logic [BURST_W-1:0]    start_cnt;
	logic [DESC_PTR_W-1:0] start_idx;
	logic [DMA_WORD_W-1:0] word0;
	logic [DMA_WORD_W-1:0] word1;

	assign cmd_fire = idma_cmd_valid && idma_cmd_ready;

	////////////////////////////////////////
	// Burst sizing
	always_comb begin
		wb_span = (DESC_PTR_W'(out_num) < wback_limit) ? DESC_PTR_W'(out_num) : wback_limit;
		wb_cnt  = (wb_span > DESC_PTR_W'(MAX_BURST)) ? BURST_W'(MAX_BURST) : BURST_W'(wb_span);

		fetch_span = (fresh_num < fetch_limit) ? fresh_num : fetch_limit;
		fetch_room = (fetch_span < DESC_PTR_W'(local_free)) ? fetch_span
			: DESC_PTR_W'(local_free);
		fetch_cnt  = (fetch_room > DESC_PTR_W'(MAX_BURST)) ? BURST_W'(MAX_BURST)
			: BURST_W'(fetch_room);
	end

	// Write-back wins when both are possible
	assign wb_go = (seq_state == SEQ_IDLE) && ring_ready && cfg.enable &&
		(out_num != '0) && (out_num >= (LOCAL_IDX_W+1)'(cfg.wthresh));
	assign fetch_go = (seq_state == SEQ_IDLE) && ring_ready && cfg.enable && !wb_go &&
		(fresh_num != '0) && (local_free != '0);

	assign start_cnt = wb_go ? wb_cnt : fetch_cnt;
	assign start_idx = wb_go ? host_head : host_curr;

	// Direction, byte count and local address
	always_comb begin
		word0 = '0;
		word0[CMD_WRITE_BIT] = wb_go;
		word0[CMD_BYTES_LSB +: CMD_BYTES_W] = CMD_BYTES_W'(start_cnt) * CMD_BYTES_W'(DESC_BYTES);
		word0[CMD_ADDR_W-1:0] = wb_go ? CMD_ADDR_W'(out_head) * CMD_ADDR_W'(DESC_BYTES)
			: CMD_ADDR_W'(in_tail) * CMD_ADDR_W'(DESC_BYTES);
	end

	assign word1 = is_write ? {host_addr[31:4], WB_STATUS_OFFSET} : host_addr[31:0];

	////////////////////////////////////////
	// Command FSM
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			seq_state      <= SEQ_IDLE;
			idma_cmd_valid <= 1'b0;
			idma_rsp_ready <= 1'b0;
			fetch_done     <= 1'b0;
			wback_done     <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			wback_done <= 1'b0;
			case (seq_state)
				SEQ_IDLE: begin
					if (wb_go || fetch_go) begin
						idma_cmd_valid <= 1'b1;
						seq_state      <= SEQ_WORD0;
					end
				end
				SEQ_WORD0: begin
					if (cmd_fire)
						seq_state <= SEQ_WORD1;
				end
				SEQ_WORD1: begin
					if (cmd_fire)
						seq_state <= SEQ_WORD2;
				end
				SEQ_WORD2: begin
					if (cmd_fire) begin
						idma_cmd_valid <= 1'b0;
						idma_rsp_ready <= 1'b1;
						seq_state      <= SEQ_RSP;
					end
				end
				SEQ_RSP: begin
					if (idma_rsp_valid && idma_rsp_last) begin
						idma_rsp_ready <= 1'b0;
						fetch_done     <= !is_write;
						wback_done     <= is_write;
						seq_state      <= SEQ_SETTLE;
					end
				end
				// Let ring_ready drop before the next decision
				SEQ_SETTLE: seq_state <= SEQ_IDLE;
				default:    seq_state <= SEQ_IDLE;
			endcase
		end
	end

	// Command words and burst bookkeeping
	always_ff @(posedge aclk) begin
		if (wb_go || fetch_go) begin
			is_write      <= wb_go;
			burst_num     <= start_cnt;
			host_addr     <= cfg.base + 64'(start_idx) * 64'(DESC_BYTES);
			idma_cmd.data <= word0;
			idma_cmd.last <= 1'b0;
		end else if (cmd_fire && seq_state == SEQ_WORD0) begin
			idma_cmd.data <= word1;
		end else if (cmd_fire && seq_state == SEQ_WORD1) begin
			idma_cmd.data <= host_addr[63:32];
			idma_cmd.last <= 1'b1;
		end
	end

	// Count qualified by the matching done pulse
	assign fetch_num = burst_num;
	assign wback_num = burst_num;

endmodule

// ==== rtl/local_desc_queue.sv ====
`timescale 1ns/10ps

module local_desc_queue import rxd_ring_pkg::*; (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic                   fetch_done,
	input  logic [BURST_W-1:0]     fetch_num,
	input  logic                   wback_done,
	input  logic [BURST_W-1:0]     wback_num,
	input  logic                   engine_taken,
	input  logic                   engine_done,
	output logic [LOCAL_IDX_W-1:0] in_head,
	output logic [LOCAL_IDX_W-1:0] in_tail,
	output logic [LOCAL_IDX_W-1:0] out_head,
	output logic [LOCAL_IDX_W:0]   in_num,
	output logic [LOCAL_IDX_W:0]   out_num,
	output logic [LOCAL_IDX_W:0]   local_free
);

	logic [LOCAL_IDX_W:0] fetch_cnt;
	logic [LOCAL_IDX_W:0] wback_cnt;

	// Zero when the matching pulse is absent
	assign fetch_cnt = fetch_done ? (LOCAL_IDX_W+1)'(fetch_num) : '0;
	assign wback_cnt = wback_done ? (LOCAL_IDX_W+1)'(wback_num) : '0;

	////////////////////////////////////////
	// Circular pointers into the store
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			in_head  <= '0;
			in_tail  <= '0;
			out_head <= '0;
		end else begin
			in_tail  <= in_tail + LOCAL_IDX_W'(fetch_cnt);
			in_head  <= in_head + LOCAL_IDX_W'(engine_taken);
			out_head <= out_head + LOCAL_IDX_W'(wback_cnt);
		end
	end

	// Counts, all events of one cycle applied together
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			in_num     <= '0;
			out_num    <= '0;
			local_free <= (LOCAL_IDX_W+1)'(LOCAL_DESC_NUM);
		end else begin
			in_num     <= in_num + fetch_cnt - (LOCAL_IDX_W+1)'(engine_taken);
			out_num    <= out_num + (LOCAL_IDX_W+1)'(engine_done) - wback_cnt;
			local_free <= local_free - fetch_cnt + wback_cnt;
		end
	end

endmodule

// ==== rtl/ring_tracker.sv ====
`timescale 1ns/10ps

module ring_tracker import rxd_ring_pkg::*; (
	input  logic                  aclk,
	input  logic                  aresetn,
	input  rxd_cfg_t              cfg,
	input  logic [DESC_PTR_W-1:0] rdt,
	input  logic                  rdt_set,
	input  logic                  fetch_done,
	input  logic [BURST_W-1:0]    fetch_num,
	input  logic                  wback_done,
	input  logic [BURST_W-1:0]    wback_num,
	output logic [DESC_PTR_W-1:0] host_head,
	output logic [DESC_PTR_W-1:0] host_curr,
	output logic [DESC_PTR_W-1:0] fresh_num,
	output logic [DESC_PTR_W-1:0] fetch_limit,
	output logic [DESC_PTR_W-1:0] wback_limit,
	output logic                  ring_ready
);

	logic [DESC_PTR_W-1:0]    ring_len;
	logic [DESC_PTR_W-1:0]    host_tail;
	logic [DESC_PTR_W:0]      curr_sum;
	logic [DESC_PTR_W:0]      head_sum;
	logic [DESC_PTR_W:0]      fresh_sum;
	logic [SETTLE_CYCLES-1:0] calc_stage;

	// Single subtraction is enough, sums never exceed twice the length
	function automatic logic [DESC_PTR_W-1:0] ring_wrap(
		input logic [DESC_PTR_W:0]   value,
		input logic [DESC_PTR_W-1:0] len
	);
		if (value >= {1'b0, len})
			return DESC_PTR_W'(value - {1'b0, len});
		else
			return DESC_PTR_W'(value);
	endfunction

	assign ring_len  = DESC_PTR_W'({cfg.rdlen, 3'b000});
	assign fresh_sum = {1'b0, host_tail} + {1'b0, ring_len} - {1'b0, host_curr};

	// Update events walk through the recalculation stages
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			calc_stage <= '0;
		else
			calc_stage <= {calc_stage[SETTLE_CYCLES-2:0], rdt_set | fetch_done | wback_done};
	end

	assign ring_ready = ~|calc_stage;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			host_tail <= '0;
		else if (rdt_set)
			host_tail <= rdt;
	end

	////////////////////////////////////////
	// Stage 1: advance and wrap pointers
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			curr_sum  <= '0;
			head_sum  <= '0;
			host_curr <= '0;
			host_head <= '0;
		end else begin
			if (fetch_done)
				curr_sum <= {1'b0, host_curr} + (DESC_PTR_W+1)'(fetch_num);
			if (wback_done)
				head_sum <= {1'b0, host_head} + (DESC_PTR_W+1)'(wback_num);
			if (calc_stage[0]) begin
				host_curr <= ring_wrap(curr_sum, ring_len);
				host_head <= ring_wrap(head_sum, ring_len);
			end
		end
	end

	////////////////////////////////////////
	// Stage 2: fresh count and room to the wrap
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			fresh_num   <= '0;
			fetch_limit <= '0;
			wback_limit <= '0;
		end else if (calc_stage[SETTLE_CYCLES-1]) begin
			fresh_num   <= ring_wrap(fresh_sum, ring_len);
			fetch_limit <= ring_len - host_curr;
			wback_limit <= ring_len - host_head;
		end
	end

endmodule

// ==== common/rxd_msg_pkg.sv ====
package rxd_msg_pkg;

	////////////////////////////////////////
	// DMA command word 0 layout

	localparam int DMA_WORD_W    = 32;
	localparam int CMD_WRITE_BIT = 31;
	localparam int CMD_BYTES_LSB = 16;
	localparam int CMD_BYTES_W   = 12;

	// Local byte address in the low half of word 0
	localparam int CMD_ADDR_W = 16;

	// Write-back begins at the status dword of the first descriptor
	localparam logic [3:0] WB_STATUS_OFFSET = 4'hC;

	////////////////////////////////////////
	// Stream payloads

	// One beat of the three-word DMA command
	typedef struct packed {
		logic [DMA_WORD_W-1:0] data;
		logic                  last;
	} dma_cmd_t;

	// Receive engine command, single beat
	typedef struct packed {
		logic [CMD_ADDR_W-1:0] addr;
	} engine_cmd_t;

endpackage

// ==== common/rxd_ring_pkg.sv ====
package rxd_ring_pkg;

	////////////////////////////////////////
	// Host descriptor ring

	// One descriptor in host memory and in the local store
	localparam int DESC_BYTES = 16;
	localparam int DESC_PTR_W = 16;

	// Ring holds rdlen * 8 descriptors
	localparam int RDLEN_W = 13;

	////////////////////////////////////////
	// Local descriptor store

	localparam int LOCAL_DESC_NUM = 256;
	localparam int LOCAL_IDX_W    = 8;

	// Largest DMA burst, in descriptors
	localparam int MAX_BURST = 64;
	localparam int BURST_W   = $clog2(MAX_BURST) + 1;

	// Pointer recalculation latency
	localparam int SETTLE_CYCLES = 2;

	// Static host settings
	typedef struct packed {
		logic               enable;
		logic [63:0]        base;
		logic [RDLEN_W-1:0] rdlen;
		logic [5:0]         wthresh;
	} rxd_cfg_t;

endpackage
